// File: Makefile
TOP = gba_sound_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f gba_sound_top.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q ">>> PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/gba_sound_sva.sv
`timescale 1ns/100ps

module gba_sound_sva #(
    parameter int CREDITS = 4
) (
    input logic                   clk_100,
    input logic                   rst_n,
    input logic                   sample_valid,
    input logic                   credit_return,
    input logic                   pending,
    input gba_sound_pkg::sample_t sample_l,
    input gba_sound_pkg::sample_t sample_r
);

    int avail;
    int next_avail;

    // credits granted by the sink and not yet used by a valid sample
    assign next_avail = avail - int'(sample_valid) + int'(credit_return);

    always_ff @(posedge clk_100) begin
        if (!rst_n) begin
            avail <= CREDITS;
        end else begin
            avail <= (next_avail > CREDITS) ? CREDITS : next_avail;
        end
    end

    credit_avail: assert property (@(posedge clk_100) disable iff (!rst_n)
        sample_valid |-> avail > 0)
        else $error("sample_valid raised with no credit available");

    single_cycle: assert property (@(posedge clk_100) disable iff (!rst_n)
        sample_valid |=> !sample_valid)
        else $error("sample_valid held longer than one cycle");

    // out of credit, so the waiting sample neither leaves nor changes
    held_stable: assert property (@(posedge clk_100) disable iff (!rst_n)
        pending && (avail == 0) && !credit_return
        |=> !sample_valid && $stable(sample_l) && $stable(sample_r))
        else $error("sample changed while pending");

endmodule

bind sound_mixer gba_sound_sva #(.CREDITS(CREDITS)) sva_i (
    .clk_100       (clk_100),
    .rst_n         (rst_n),
    .sample_valid  (sample_valid),
    .credit_return (credit_return),
    .pending       (pending),
    .sample_l      (sample_l),
    .sample_r      (sample_r)
);

// File: bench/gba_sound_tb.sv
`timescale 1ns/100ps

module gba_sound_tb;
    import gba_sound_pkg::*;

    localparam int SAMPLE_DIV       = 16;
    localparam int CREDITS          = 4;
    localparam int N_TESTS          = 5;
    localparam int SAMPLES_PER_TEST = 8;
    localparam int CYCLE_LIMIT      = N_TESTS * SAMPLES_PER_TEST * SAMPLE_DIV * 4;

    logic        clk_100 = 1'b0;
    logic        rst_n;
    logic        reg_wr;
    sound_addr_t reg_addr;
    logic [15:0] reg_wdata;
    logic        credit_return = 1'b0;
    logic        sample_valid;
    sample_t     sample_l;
    sample_t     sample_r;
    logic        fifo_req;

    integer    seed = 32'hac5e;
    int        errors;
    int        checks;
    int        test_errors;
    int        test_num;
    int        cycles;
    int        last_cycle;
    int        sample_cnt;
    int        owed;
    int        wait_cnt;
    bit        hold_credits;
    bit        check_gap;
    snd_ctrl_t ctrl_model;
    int        sq_vol;
    byte       exp_q[$];

    gba_sound_top #(
        .SAMPLE_DIV (SAMPLE_DIV),
        .CREDITS    (CREDITS),
        .FIFO_DEPTH (8)
    ) dut_i (
        .clk_100       (clk_100),
        .rst_n         (rst_n),
        .reg_wr        (reg_wr),
        .reg_addr      (reg_addr),
        .reg_wdata     (reg_wdata),
        .credit_return (credit_return),
        .sample_valid  (sample_valid),
        .sample_l      (sample_l),
        .sample_r      (sample_r),
        .fifo_req      (fifo_req)
    );

    always #5 clk_100 = ~clk_100;

    // expected output of one side from the mixing rule
    function automatic int mix_ref(input snd_ctrl_t c, input bit left, input int ds,
                                   input int sq_lvl);
        int sq;
        int d;
        bit sq_en;
        bit ds_en;
        sq_en = left ? c.sq_left : c.sq_right;
        ds_en = left ? c.ds_left : c.ds_right;
        sq    = 0;
        d     = 0;
        if (sq_en) begin
            sq = (sq_lvl * 16 * (int'(c.master_vol) + 1)) / 2;
        end
        if (ds_en) begin
            d = c.ds_full ? ds * 8 : ds * 4;
        end
        return sq + d;
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got 0x%04h expected 0x%04h", name, got, exp);
        end
    endtask

    task automatic write_reg(input sound_addr_t addr, input logic [15:0] data);
        @(negedge clk_100);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clk_100);
        reg_wr = 1'b0;
        // samples fired from the next edge on see the new value
        @(posedge clk_100);
    endtask

    task automatic write_fifo(input logic [15:0] data);
        write_reg(ADDR_FIFO_A, data);
        exp_q.push_back(byte'(data[7:0]));
        exp_q.push_back(byte'(data[15:8]));
    endtask

    task automatic write_ctrl(input snd_ctrl_t ctrl);
        write_reg(ADDR_SND_CTRL, ctrl);
        ctrl_model = ctrl;
    endtask

    task automatic wait_samples(input int n);
        int target;
        target = sample_cnt + n;
        wait (sample_cnt >= target);
    endtask

    task automatic end_test(input string name);
        test_num++;
        if (errors == test_errors) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: %0d errors", test_num, name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    always @(posedge clk_100) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display(">>> FAIL");
            $finish;
        end
    end

    // compares each sample and plays the sink returning credits
    always @(negedge clk_100) begin : compare_blk
        int ds;
        int exp_l;
        int exp_r;
        credit_return = 1'b0;
        if (!rst_n) begin
            last_cycle = cycles;
        end else if (sample_valid) begin
            ds = 0;
            if (exp_q.size() > 0) begin
                ds = int'(exp_q.pop_front());
            end
            exp_l = mix_ref(ctrl_model, 1'b1, ds, sq_vol);
            exp_r = mix_ref(ctrl_model, 1'b0, ds, sq_vol);
            // square level may sit in either half of its duty cycle
            if (sample_l !== 16'(exp_l) || sample_r !== 16'(exp_r)) begin
                exp_l = mix_ref(ctrl_model, 1'b1, ds, -sq_vol);
                exp_r = mix_ref(ctrl_model, 1'b0, ds, -sq_vol);
            end
            check_value("sample_l", sample_l, 16'(exp_l));
            check_value("sample_r", sample_r, 16'(exp_r));
            if (check_gap && (cycles - last_cycle > SAMPLE_DIV + 1)) begin
                errors++;
                $display("samples came %0d cycles apart, too slow", cycles - last_cycle);
            end
            last_cycle = cycles;
            sample_cnt++;
            owed++;
        end
        if (owed > 0 && !hold_credits) begin
            if (wait_cnt == 0) begin
                credit_return = 1'b1;
                owed--;
                wait_cnt = $random(seed) & 3;
            end else begin
                wait_cnt--;
            end
        end
    end

    initial begin : main_blk
        snd_ctrl_t ctrl;
        sq_ctrl_t  sq;
        int        n;
        int        i;
        rst_n        = 1'b0;
        reg_wr       = 1'b0;
        reg_addr     = '0;
        reg_wdata    = '0;
        ctrl_model   = '0;
        sq_vol       = 0;
        hold_credits = 1'b0;
        check_gap    = 1'b0;
        repeat (3) @(negedge clk_100);
        rst_n = 1'b1;

        check_value("sample_valid", 16'(sample_valid), 16'h0);
        check_value("fifo_req", 16'(fifo_req), 16'h1);
        check_gap = 1'b1;
        wait_samples(4);
        check_gap = 1'b0;
        end_test("reset and sample rate");

        ctrl          = '0;
        ctrl.ds_left  = 1'b1;
        ctrl.ds_right = 1'b1;
        write_ctrl(ctrl);
        write_fifo(16'($random(seed)));
        write_fifo(16'($random(seed)));
        @(negedge clk_100);
        check_value("fifo_req", 16'(fifo_req), 16'h1);
        write_fifo(16'($random(seed)));
        @(negedge clk_100);
        check_value("fifo_req", 16'(fifo_req), 16'h0);
        wait_samples(3);
        ctrl.ds_full = 1'b1;
        write_ctrl(ctrl);
        wait_samples(3);
        // drained, zeros follow
        wait_samples(2);
        check_value("fifo_req", 16'(fifo_req), 16'h1);
        end_test("direct sound order and scaling");

        ctrl         = '0;
        ctrl.ds_left = 1'b1;
        write_ctrl(ctrl);
        write_fifo(16'($random(seed)));
        write_fifo(16'($random(seed)));
        wait_samples(4);
        end_test("left only direct sound");

        sq        = '0;
        sq.volume = 4'd9;
        sq.duty   = 2'd2;
        write_reg(ADDR_SQ_CTRL, sq);
        sq_vol = 9;
        // short period so the level flips between samples
        write_reg(ADDR_SQ_FREQ, 16'h8000 | 16'd2045);
        ctrl            = '0;
        ctrl.sq_left    = 1'b1;
        ctrl.sq_right   = 1'b1;
        ctrl.master_vol = 3'd5;
        write_ctrl(ctrl);
        wait_samples(6);
        sq.volume = 4'd0;
        write_reg(ADDR_SQ_CTRL, sq);
        sq_vol = 0;
        wait_samples(3);
        end_test("square channel levels");

        ctrl          = '0;
        ctrl.ds_left  = 1'b1;
        ctrl.ds_right = 1'b1;
        write_ctrl(ctrl);
        for (i = 0; i < 4; i++) begin
            write_fifo(16'($random(seed)));
        end
        hold_credits = 1'b1;
        n = sample_cnt;
        repeat ((CREDITS + 2) * SAMPLE_DIV) @(posedge clk_100);
        if (sample_cnt - n > CREDITS) begin
            errors++;
            $display("%0d samples went out while credits were withheld", sample_cnt - n);
        end
        hold_credits = 1'b0;
        while (exp_q.size() > 0) begin
            wait_samples(1);
        end
        wait_samples(1);
        end_test("back-pressure");

        $display("tests: %0d, checks: %0d, errors: %0d", test_num, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: gba_sound_top.f
source/gba_sound_pkg.sv
source/sound_cfg_if.sv
source/sound_reg_decode.sv
source/square_channel.sv
source/direct_sound_fifo.sv
source/sound_mixer.sv
source/gba_sound_top.sv
bench/gba_sound_sva.sv
bench/gba_sound_tb.sv

// File: source/direct_sound_fifo.sv
`timescale 1ns/100ps

module direct_sound_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic              clk_100,
    input  logic              rst_n,
    sound_cfg_if.fifo         cfg,
    input  logic              pop,
    output logic signed [7:0] sample,
    output logic              req
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic signed [7:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              head_valid_q;
    logic              push;
    logic              pop_ok;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end else begin
            return ptr + 1'b1;
        end
    endfunction

    // a write needs room for both bytes
    assign push = cfg.fifo_wr && (count <= CNT_W'(FIFO_DEPTH - 2));

    // mixer captured the head a cycle before it pops, so only pop
    // if something was there then
    assign pop_ok = pop && head_valid_q;

    always_ff @(posedge clk_100) begin
        if (!rst_n) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            head_valid_q <= 1'b0;
        end else begin
            head_valid_q <= (count != '0);
            if (push) begin
                wr_ptr <= next_ptr(next_ptr(wr_ptr));
            end
            if (pop_ok) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + (push ? CNT_W'(2) : CNT_W'(0)) - (pop_ok ? CNT_W'(1) : CNT_W'(0));
        end
    end

    always_ff @(posedge clk_100) begin
        if (push) begin
            mem[wr_ptr]           <= cfg.fifo_wdata[7:0];
            mem[next_ptr(wr_ptr)] <= cfg.fifo_wdata[15:8];
        end
    end

    assign sample = (count != '0) ? mem[rd_ptr] : '0;
    assign req    = (count <= CNT_W'(FIFO_DEPTH / 2));

endmodule

// File: source/gba_sound_pkg.sv
package gba_sound_pkg;

    typedef logic [3:0] sound_addr_t;

    localparam sound_addr_t ADDR_SQ_CTRL  = 4'h0;
    localparam sound_addr_t ADDR_SQ_FREQ  = 4'h2;
    localparam sound_addr_t ADDR_SND_CTRL = 4'h4;
    localparam sound_addr_t ADDR_FIFO_A   = 4'h8;

    // square duty and volume, laid out like SOUND1CNT_H
    typedef struct packed {
        logic [3:0] volume;
        logic [3:0] rsvd_hi;
        logic [1:0] duty;
        logic [5:0] rsvd_lo;
    } sq_ctrl_t;

    // master volume and per-side enables
    typedef struct packed {
        logic [7:0] rsvd;
        logic       ds_full;
        logic       ds_left;
        logic       ds_right;
        logic       sq_left;
        logic       sq_right;
        logic [2:0] master_vol;
    } snd_ctrl_t;

    typedef union packed {
        sq_ctrl_t  sq;
        snd_ctrl_t snd;
    } reg_word_u;

    typedef logic signed [15:0] sample_t;

    localparam int SQ_LEVEL_SCALE = 4;

endpackage

// File: source/gba_sound_top.sv
`timescale 1ns/100ps

module gba_sound_top #(
    parameter int SAMPLE_DIV = 64,
    parameter int CREDITS    = 4,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                       clk_100,
    input  logic                       rst_n,
    input  logic                       reg_wr,
    input  gba_sound_pkg::sound_addr_t reg_addr,
    input  logic [15:0]                reg_wdata,
    input  logic                       credit_return,
    output logic                       sample_valid,
    output gba_sound_pkg::sample_t     sample_l,
    output gba_sound_pkg::sample_t     sample_r,
    output logic                       fifo_req
);

    logic signed [5:0] sq_level;
    logic signed [7:0] ds_sample;
    logic              pop;

    sound_cfg_if cfg_if ();

    sound_reg_decode decode_i (
        .clk_100   (clk_100),
        .rst_n     (rst_n),
        .reg_wr    (reg_wr),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .cfg       (cfg_if.decoder)
    );

    square_channel square_i (
        .clk_100 (clk_100),
        .rst_n   (rst_n),
        .cfg     (cfg_if.square),
        .level   (sq_level)
    );

    direct_sound_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_a_i (
        .clk_100 (clk_100),
        .rst_n   (rst_n),
        .cfg     (cfg_if.fifo),
        .pop     (pop),
        .sample  (ds_sample),
        .req     (fifo_req)
    );

    sound_mixer #(.SAMPLE_DIV(SAMPLE_DIV), .CREDITS(CREDITS)) mixer_i (
        .clk_100       (clk_100),
        .rst_n         (rst_n),
        .cfg           (cfg_if.mixer),
        .sq_level      (sq_level),
        .ds_sample     (ds_sample),
        .credit_return (credit_return),
        .pop           (pop),
        .sample_valid  (sample_valid),
        .sample_l      (sample_l),
        .sample_r      (sample_r)
    );

endmodule

// File: source/sound_cfg_if.sv
`timescale 1ns/100ps

interface sound_cfg_if;
    import gba_sound_pkg::*;

    // square channel fields
    logic [1:0]  sq_duty;
    logic [3:0]  sq_volume;
    logic [10:0] sq_freq;
    logic        sq_trigger;

    snd_ctrl_t   snd_ctrl;

    // two samples per write, low byte plays first
    logic        fifo_wr;
    logic [15:0] fifo_wdata;

    modport decoder (
        output sq_duty,
        output sq_volume,
        output sq_freq,
        output sq_trigger,
        output snd_ctrl,
        output fifo_wr,
        output fifo_wdata
    );

    modport square (
        input sq_duty,
        input sq_volume,
        input sq_freq,
        input sq_trigger
    );

    modport fifo (input fifo_wr, input fifo_wdata);

    modport mixer (input snd_ctrl);

endinterface

// File: source/sound_mixer.sv
`timescale 1ns/100ps

module sound_mixer #(
    parameter int SAMPLE_DIV = 64,
    parameter int CREDITS    = 4
) (
    input  logic                   clk_100,
    input  logic                   rst_n,
    sound_cfg_if.mixer             cfg,
    input  logic signed [5:0]      sq_level,
    input  logic signed [7:0]      ds_sample,
    input  logic                   credit_return,
    output logic                   pop,
    output logic                   sample_valid,
    output gba_sound_pkg::sample_t sample_l,
    output gba_sound_pkg::sample_t sample_r
);
    import gba_sound_pkg::*;

    localparam int DIV_W  = $clog2(SAMPLE_DIV);
    localparam int CRED_W = $clog2(CREDITS + 1);

    logic [DIV_W-1:0]  div_cnt;
    logic              tick;
    logic              pending;
    logic              fire;
    logic [CRED_W-1:0] credit_cnt;

    function automatic sample_t mix_side(input logic sq_en, input logic ds_en);
        sample_t sq_term;
        sample_t ds_term;
        sample_t vol_mult;
        vol_mult = sample_t'({1'b0, cfg.snd_ctrl.master_vol}) + 16'sd1;
        sq_term  = sq_en ? (sample_t'(sq_level) <<< SQ_LEVEL_SCALE) : '0;
        sq_term  = (sq_term * vol_mult) >>> 1;
        ds_term  = '0;
        if (ds_en) begin
            ds_term = sample_t'(ds_sample) <<< (cfg.snd_ctrl.ds_full ? 3 : 2);
        end
        return sq_term + ds_term;
    endfunction

    assign tick = (div_cnt == DIV_W'(SAMPLE_DIV - 1));

    // a returning credit can be spent in the same cycle
    assign fire = (tick || pending) && ((credit_cnt != '0) || credit_return);

    always_ff @(posedge clk_100) begin
        if (!rst_n) begin
            div_cnt      <= '0;
            pending      <= 1'b0;
            sample_valid <= 1'b0;
            credit_cnt   <= CRED_W'(CREDITS);
        end else begin
            div_cnt      <= tick ? '0 : div_cnt + 1'b1;
            // extra ticks while waiting are dropped
            pending      <= (tick || pending) && !fire;
            sample_valid <= fire;
            case ({fire, credit_return})
                2'b10: credit_cnt <= credit_cnt - 1'b1;
                2'b01: begin
                    if (credit_cnt != CRED_W'(CREDITS)) begin
                        credit_cnt <= credit_cnt + 1'b1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // held until the next sample goes out
    always_ff @(posedge clk_100) begin
        if (fire) begin
            sample_l <= mix_side(cfg.snd_ctrl.sq_left, cfg.snd_ctrl.ds_left);
            sample_r <= mix_side(cfg.snd_ctrl.sq_right, cfg.snd_ctrl.ds_right);
        end
    end

    assign pop = sample_valid;

endmodule

// File: source/sound_reg_decode.sv
`timescale 1ns/100ps

module sound_reg_decode (
    input  logic                       clk_100,
    input  logic                       rst_n,
    input  logic                       reg_wr,
    input  gba_sound_pkg::sound_addr_t reg_addr,
    input  logic [15:0]                reg_wdata,
    sound_cfg_if.decoder               cfg
);
    import gba_sound_pkg::*;

    reg_word_u   word;
    sq_ctrl_t    sq_ctrl_q;
    logic [10:0] sq_freq_q;
    logic        trigger_q;
    snd_ctrl_t   snd_ctrl_q;

    // same data word, read per address
    assign word = reg_wdata;

    always_ff @(posedge clk_100) begin
        if (!rst_n) begin
            sq_ctrl_q  <= '0;
            sq_freq_q  <= '0;
            trigger_q  <= 1'b0;
            snd_ctrl_q <= '0;
        end else begin
            trigger_q <= 1'b0;
            if (reg_wr) begin
                case (reg_addr)
                    ADDR_SQ_CTRL: begin
                        sq_ctrl_q <= word.sq;
                    end
                    ADDR_SQ_FREQ: begin
                        sq_freq_q <= reg_wdata[10:0];
                        // bit 15 restarts the tone
                        trigger_q <= reg_wdata[15];
                    end
                    ADDR_SND_CTRL: begin
                        snd_ctrl_q <= word.snd;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    assign cfg.sq_duty    = sq_ctrl_q.duty;
    assign cfg.sq_volume  = sq_ctrl_q.volume;
    assign cfg.sq_freq    = sq_freq_q;
    assign cfg.sq_trigger = trigger_q;
    assign cfg.snd_ctrl   = snd_ctrl_q;

    // fifo stores on this same edge, so pass straight through
    assign cfg.fifo_wr    = reg_wr && (reg_addr == ADDR_FIFO_A);
    assign cfg.fifo_wdata = reg_wdata;

endmodule

// File: source/square_channel.sv
`timescale 1ns/100ps

module square_channel (
    input  logic              clk_100,
    input  logic              rst_n,
    sound_cfg_if.square       cfg,
    output logic signed [5:0] level
);

    logic        active;
    logic [11:0] timer;
    logic [2:0]  pos;
    logic [11:0] reload;
    logic [7:0]  pattern;
    logic        duty_high;

    // period in clocks is 2048 - freq
    assign reload = 12'd2048 - {1'b0, cfg.sq_freq};

    always_comb begin
        case (cfg.sq_duty)
            2'd0:    pattern = 8'b0000_0001;
            2'd1:    pattern = 8'b1000_0001;
            2'd2:    pattern = 8'b1000_0111;
            default: pattern = 8'b0111_1110;
        endcase
    end

    assign duty_high = pattern[pos];

    always_ff @(posedge clk_100) begin
        if (!rst_n) begin
            active <= 1'b0;
            timer  <= '0;
            pos    <= '0;
        end else if (cfg.sq_trigger) begin
            active <= 1'b1;
            timer  <= reload;
            pos    <= '0;
        end else if (active) begin
            if (timer == 12'd1) begin
                timer <= reload;
                pos   <= pos + 3'd1;
            end else begin
                timer <= timer - 12'd1;
            end
        end
    end

    // silent until first trigger
    always_comb begin
        if (!active) begin
            level = '0;
        end else if (duty_high) begin
            level = $signed({2'b00, cfg.sq_volume});
        end else begin
            level = -$signed({2'b00, cfg.sq_volume});
        end
    end

endmodule
